//--- files.f
verilog/dpr_alu_pkg.sv
verilog/dpr_ctrl_pkg.sv
verilog/arith_unit.sv
verilog/rp_decoupler.sv
verilog/decouple_ctrl.sv
verilog/dpr_top.sv
verification/tb_clock_gen.sv
verification/dpr_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dpr_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f files.f --top-module dpr_top_tb -Mdir "$BUILD_DIR" -o dpr_top_tb
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/dpr_top_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Verification passed" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

//--- verification/dpr_top_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dpr_top_tb
  import dpr_alu_pkg::*;
();

  localparam int DATA_W        = 8;
  localparam int RM_CYCLES     = 2;
  localparam int CLK_PERIOD_NS = 100;
  localparam int OPS_REPS      = 4;
  // Reset, then the six tests, two closing edges each
  localparam int TOTAL_CYCLES  = 2 + 32 * OPS_REPS + 40 + 18 + 32 + (RM_CYCLES + 5) + 12 + 6 * 2;
  localparam int TIMEOUT_NS    = (TOTAL_CYCLES + 20) * CLK_PERIOD_NS;
  localparam longint L0        = 0;
  localparam longint L1        = 1;
  localparam longint MASK      = (L1 << DATA_W) - L1;
  // Model controller states
  localparam logic [1:0] ST_ACTIVE    = 2'd0;
  localparam logic [1:0] ST_DECOUPLED = 2'd1;
  localparam logic [1:0] ST_RESETTING = 2'd2;

  logic              clk;
  logic              rst_i;
  logic [DATA_W-1:0] a_i;
  logic [DATA_W-1:0] b_i;
  alu_op_e           op_sel_i;
  logic              mux_sel_i;
  logic              shutdown_req_i;
  logic              startup_req_i;
  logic [DATA_W-1:0] result_o;
  logic              lt_o;
  logic              gt_o;
  logic              eq_o;
  logic              decouple_status_o;
  logic              rm_reset_o;
  logic              event_error_o;

  // Reference model state
  logic              model_valid = 1'b0;
  logic [1:0]        m_state;
  int                m_left;
  logic [DATA_W-1:0] m_reg;
  logic [DATA_W-1:0] exp_result;
  logic [2:0]        exp_flags;
  logic              exp_live;
  logic              exp_err;
  logic              exp_decouple;
  logic              exp_rm_reset;
  int                rm_len = 0;

  // Bookkeeping
  int    seed;
  int    err_count = 0;
  int    test_errs = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  string test_name = "reset";

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock_gen (.clk_o(clk));

  dpr_top DUT (
    .clk               (clk),
    .rst_i             (rst_i),
    .a_i               (a_i),
    .b_i               (b_i),
    .op_sel_i          (op_sel_i),
    .mux_sel_i         (mux_sel_i),
    .shutdown_req_i    (shutdown_req_i),
    .startup_req_i     (startup_req_i),
    .result_o          (result_o),
    .lt_o              (lt_o),
    .gt_o              (gt_o),
    .eq_o              (eq_o),
    .decouple_status_o (decouple_status_o),
    .rm_reset_o        (rm_reset_o),
    .event_error_o     (event_error_o)
  );

  // Operation rules worked in 64-bit integers, then cut to the operand width
  function automatic logic [DATA_W-1:0] model_result(input int code,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b, input logic ms,
      input logic [DATA_W-1:0] held);
    longint ai;
    longint bi;
    longint r;
    ai = longint'(a);
    bi = longint'(b);
    case (code)
      0:  r = ai + bi;
      1:  r = ai - L1;
      2:  r = (bi == L0) ? MASK : ai / bi;
      3:  r = ai + L1;
      4:  r = (bi == L0) ? ai : ai % bi;
      5:  r = ai * bi;
      6:  r = ms ? bi : ai;
      7:  r = longint'(held);
      8:  r = (bi >= longint'(DATA_W)) ? L0 : ai << bi;
      9:  r = (bi >= longint'(DATA_W)) ? L0 : ai >> bi;
      10: r = ai - bi;
      default: r = L0;
    endcase
    // Negative differences wrap through the mask
    return DATA_W'(r & MASK);
  endfunction

  // Flag order lt, gt, eq
  function automatic logic [2:0] model_flags(input logic [DATA_W-1:0] a,
      input logic [DATA_W-1:0] b);
    longint diff;
    diff = longint'(a) - longint'(b);
    return {diff < L0, diff > L0, diff == L0};
  endfunction

  assign exp_decouple = (m_state != ST_ACTIVE);
  assign exp_rm_reset = (m_state == ST_RESETTING);

  // Model follows the inputs the DUT samples at each edge
  always @(posedge clk) begin
    if (rst_i) begin
      model_valid <= 1'b1;
      m_state     <= ST_ACTIVE;
      m_left      <= 0;
      m_reg       <= '0;
      exp_result  <= '0;
      exp_flags   <= 3'b000;
      exp_live    <= 1'b0;
      exp_err     <= 1'b0;
    end else begin
      // Startup only legal while decoupled
      exp_err  <= startup_req_i && (m_state != ST_DECOUPLED);
      // Held mux value, cleared during module reset
      m_reg    <= exp_rm_reset ? '0 : (mux_sel_i ? b_i : a_i);
      exp_live <= !exp_decouple;
      if (exp_decouple) begin
        exp_result <= '0;
        exp_flags  <= 3'b000;
      end else begin
        exp_result <= model_result(int'(op_sel_i), a_i, b_i, mux_sel_i, m_reg);
        exp_flags  <= model_flags(a_i, b_i);
      end
      // Controller, shutdown first
      if (shutdown_req_i) begin
        m_state <= ST_DECOUPLED;
      end else if ((m_state == ST_DECOUPLED) && startup_req_i) begin
        m_state <= ST_RESETTING;
        m_left  <= RM_CYCLES;
      end else if (m_state == ST_RESETTING) begin
        if (m_left <= 1) begin
          m_state <= ST_ACTIVE;
        end else begin
          m_left <= m_left - 1;
        end
      end
    end
  end

  // Length of the current module reset run
  always @(posedge clk) begin
    rm_len <= rm_reset_o ? rm_len + 1 : 0;
  end

  task automatic report_value(input string what, input logic [DATA_W-1:0] exp_v,
      input logic [DATA_W-1:0] act_v);
    err_count++;
    $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
  endtask

  task automatic report_fault(input string msg);
    err_count++;
    $display("Test %s: %s", test_name, msg);
  endtask

  a_result: assert property (@(posedge clk) disable iff (!model_valid)
    result_o == exp_result)
    else report_value("result", $sampled(exp_result), $sampled(result_o));

  a_flags: assert property (@(posedge clk) disable iff (!model_valid)
    {lt_o, gt_o, eq_o} == exp_flags)
    else report_value("flags lt/gt/eq", DATA_W'($sampled(exp_flags)),
                      DATA_W'($sampled({lt_o, gt_o, eq_o})));

  a_ctrl: assert property (@(posedge clk) disable iff (!model_valid)
    {decouple_status_o, rm_reset_o, event_error_o} == {exp_decouple, exp_rm_reset, exp_err})
    else report_value("decouple/rm_reset/error",
                      DATA_W'($sampled({exp_decouple, exp_rm_reset, exp_err})),
                      DATA_W'($sampled({decouple_status_o, rm_reset_o, event_error_o})));

  a_onehot: assert property (@(posedge clk) disable iff (!model_valid)
    exp_live |-> $onehot({lt_o, gt_o, eq_o}))
    else report_fault("comparator flags are not exactly one high");

  a_isolated: assert property (@(posedge clk) disable iff (!model_valid)
    decouple_status_o |=> ((result_o == '0) && ({lt_o, gt_o, eq_o} == 3'b000)))
    else report_fault("outputs not cleared while decoupled");

  a_reset_len: assert property (@(posedge clk) disable iff (!model_valid)
    $fell(rm_reset_o) |-> (rm_len == RM_CYCLES))
    else report_value("module reset cycles", DATA_W'(RM_CYCLES), DATA_W'($sampled(rm_len)));

  a_reg_coupled: assert property (@(posedge clk) disable iff (!model_valid)
    ($fell(decouple_status_o) && (op_sel_i == OP_REG)) |=> (result_o == '0))
    else report_value("register after startup", '0, $sampled(result_o));

  // One set of inputs, driven just after a rising edge
  task automatic drive(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
      input int code, input logic ms, input logic shut, input logic start, input logic rst);
    @(posedge clk);
    rst_i          <= rst;
    a_i            <= a;
    b_i            <= b;
    op_sel_i       <= alu_op_e'(code[OP_SEL_WIDTH-1:0]);
    mux_sel_i      <= ms;
    shutdown_req_i <= shut;
    startup_req_i  <= start;
  endtask

  // Random operands, legal code
  task automatic drive_random(input logic shut, input logic start);
    drive(DATA_W'($random(seed)), DATA_W'($random(seed)), $unsigned($random(seed)) % 11,
          1'($random(seed)), shut, start, 1'b0);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = err_count;
  endtask

  task automatic end_test;
    // Last results drain before scoring
    repeat (2) @(posedge clk);
    #1;
    tests_run++;
    if (err_count == test_errs) begin
      $display("Test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d failed checks", test_name, err_count - test_errs);
    end
  endtask

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: tests still running after %0d cycles", TOTAL_CYCLES + 20);
    $display("Verification failed");
    $finish;
  end

  initial begin
    int                i;
    int                code;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    seed           = 36;
    rst_i          = 1'b1;
    a_i            = '0;
    b_i            = '0;
    op_sel_i       = OP_ADD;
    mux_sel_i      = 1'b0;
    shutdown_req_i = 1'b0;
    startup_req_i  = 1'b0;
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;

    // Every code, unused ones included
    start_test("all_codes");
    for (code = 0; code < 32; code++) begin
      for (i = 0; i < OPS_REPS; i++) begin
        a = DATA_W'($random(seed));
        b = DATA_W'($random(seed));
        // Zero divisor on the first pass
        if ((i == 0) && ((code == int'(OP_DIV)) || (code == int'(OP_MOD)))) begin
          b = '0;
        end
        drive(a, b, code, 1'($random(seed)), 1'b0, 1'b0, 1'b0);
      end
    end
    end_test();

    start_test("compare");
    for (i = 0; i < 40; i++) begin
      a = DATA_W'($random(seed));
      // Every fourth pair equal
      b = (i % 4 == 0) ? a : DATA_W'($random(seed));
      drive(a, b, $unsigned($random(seed)) % 11, 1'($random(seed)), 1'b0, 1'b0, 1'b0);
    end
    end_test();

    // Reset pulse of two cycles in the middle
    start_test("reg_operator");
    for (i = 0; i < 18; i++) begin
      drive(DATA_W'($random(seed)), DATA_W'($random(seed)), int'(OP_REG), 1'($random(seed)),
            1'b0, 1'b0, (i == 12) || (i == 13));
    end
    end_test();

    // Shutdown level held across all codes
    start_test("shutdown");
    for (code = 0; code < 32; code++) begin
      drive(DATA_W'($random(seed)), DATA_W'($random(seed)), code, 1'($random(seed)),
            1'b1, 1'b0, 1'b0);
    end
    end_test();

    start_test("startup");
    drive(DATA_W'($random(seed)), DATA_W'($random(seed)), int'(OP_REG), 1'($random(seed)),
          1'b0, 1'b1, 1'b0);
    for (i = 0; i < RM_CYCLES + 4; i++) begin
      drive(DATA_W'($random(seed)), DATA_W'($random(seed)), int'(OP_REG), 1'($random(seed)),
            1'b0, 1'b0, 1'b0);
    end
    end_test();

    start_test("startup_error");
    // Out of order while active
    drive_random(1'b0, 1'b1);
    repeat (3) drive_random(1'b0, 1'b0);
    // Legal startup, then a second one during module reset
    drive_random(1'b1, 1'b0);
    drive_random(1'b0, 1'b1);
    drive_random(1'b0, 1'b1);
    repeat (5) drive_random(1'b0, 1'b0);
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  // Free-running clock, low at time zero
  // First rising edge half a period in
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dpr_top.sv
`timescale 1ns/100ps
`default_nettype none

module dpr_top
  import dpr_alu_pkg::*;
  import dpr_ctrl_pkg::*;
#(
  parameter int DATA_WIDTH      = DEFAULT_DATA_WIDTH,
  parameter int RM_RESET_CYCLES = DEFAULT_RM_RESET_CYCLES
) (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire  [DATA_WIDTH-1:0] a_i,
  input  wire  [DATA_WIDTH-1:0] b_i,
  input  alu_op_e               op_sel_i,
  input  wire                   mux_sel_i,
  input  wire                   shutdown_req_i,
  input  wire                   startup_req_i,
  output logic [DATA_WIDTH-1:0] result_o,
  output logic                  lt_o,
  output logic                  gt_o,
  output logic                  eq_o,
  output logic                  decouple_status_o,
  output logic                  rm_reset_o,
  output logic                  event_error_o
);

  // Partition side, unregistered
  logic [DATA_WIDTH-1:0] rm_result;
  cmp_flags_t            rm_flags;
  // Static side, after isolation
  cmp_flags_t            flags_q;

  // Reconfiguration controller
  decouple_ctrl #(
    .RM_RESET_CYCLES (RM_RESET_CYCLES)
  ) u_decouple_ctrl (
    .clk            (clk),
    .rst_i          (rst_i),
    .shutdown_req_i (shutdown_req_i),
    .startup_req_i  (startup_req_i),
    .decouple_o     (decouple_status_o),
    .rm_reset_o     (rm_reset_o),
    .event_error_o  (event_error_o)
  );

  // Reconfigurable module
  arith_unit #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_arith_unit (
    .clk        (clk),
    .rst_i      (rst_i),
    .rm_reset_i (rm_reset_o),
    .a_i        (a_i),
    .b_i        (b_i),
    .op_sel_i   (op_sel_i),
    .mux_sel_i  (mux_sel_i),
    .result_o   (rm_result),
    .flags_o    (rm_flags)
  );

  // Result isolation, also the output register
  rp_decoupler #(
    .payload_t (logic [DATA_WIDTH-1:0])
  ) u_result_decoupler (
    .clk        (clk),
    .rst_i      (rst_i),
    .decouple_i (decouple_status_o),
    .payload_i  (rm_result),
    .payload_o  (result_o)
  );

  // Flag isolation
  rp_decoupler #(
    .payload_t (cmp_flags_t)
  ) u_flags_decoupler (
    .clk        (clk),
    .rst_i      (rst_i),
    .decouple_i (decouple_status_o),
    .payload_i  (rm_flags),
    .payload_o  (flags_q)
  );

  // Flags out as loose bits
  assign lt_o = flags_q.lt;
  assign gt_o = flags_q.gt;
  assign eq_o = flags_q.eq;

endmodule

`default_nettype wire

//--- verilog/decouple_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module decouple_ctrl
  import dpr_ctrl_pkg::*;
#(
  parameter int RM_RESET_CYCLES = DEFAULT_RM_RESET_CYCLES
) (
  input  wire  clk,
  input  wire  rst_i,
  input  wire  shutdown_req_i,
  input  wire  startup_req_i,
  output logic decouple_o,
  output logic rm_reset_o,
  output logic event_error_o
);

  // Counter only needs to reach RM_RESET_CYCLES-1
  localparam int CNT_W = (RM_RESET_CYCLES > 1) ? $clog2(RM_RESET_CYCLES) : 1;
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(RM_RESET_CYCLES - 1);

  rm_state_e        state_q;
  rm_state_e        state_d;
  logic [CNT_W-1:0] cnt_q;
  logic             startup_bad;

  // Startup is only legal once the module is decoupled
  assign startup_bad = startup_req_i &&
                       ((state_q == RM_ACTIVE) || (state_q == RM_RESETTING));

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      RM_ACTIVE: begin
        state_d = RM_ACTIVE;
      end
      RM_DECOUPLED: begin
        if (startup_req_i) begin
          state_d = RM_RESETTING;
        end
      end
      RM_RESETTING: begin
        // Last reset cycle
        if (cnt_q == '0) begin
          state_d = RM_ACTIVE;
        end
      end
      default: state_d = RM_ACTIVE;
    endcase
    // Shutdown wins from any state
    if (shutdown_req_i) begin
      state_d = RM_DECOUPLED;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q       <= RM_ACTIVE;
      cnt_q         <= '0;
      event_error_o <= 1'b0;
    end else begin
      state_q       <= state_d;
      event_error_o <= startup_bad;
      // Load on entry to the reset phase, count down inside it
      if (state_q != RM_RESETTING) begin
        cnt_q <= CNT_LOAD;
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

  // Isolation covers both the idle and the reset phase
  assign decouple_o = (state_q != RM_ACTIVE);
  assign rm_reset_o = (state_q == RM_RESETTING);

  // Module never sees reset while coupled
  a_reset_decoupled: assert property (
    @(posedge clk) disable iff (rst_i)
    rm_reset_o |-> decouple_o
  ) else $error("decouple_ctrl: module reset while coupled");

  // Error is a single-cycle event
  a_error_pulse: assert property (
    @(posedge clk) disable iff (rst_i)
    event_error_o |=> !event_error_o
  ) else $error("decouple_ctrl: event error held for two cycles");

endmodule

`default_nettype wire

//--- verilog/rp_decoupler.sv
`timescale 1ns/100ps
`default_nettype none

module rp_decoupler #(
  parameter type payload_t = logic
) (
  input  wire      clk,
  input  wire      rst_i,
  input  wire      decouple_i,
  input  payload_t payload_i,
  output payload_t payload_o
);

  // Isolation register on the partition boundary
  // Static side only ever sees a registered value
  // Partition outputs may toggle freely while being replaced
  always_ff @(posedge clk) begin
    if (rst_i || decouple_i) begin
      // Forced to zero while isolated
      payload_o <= '0;
    end else begin
      payload_o <= payload_i;
    end
  end

  // No payload leaks out during isolation
  a_isolated_zero: assert property (
    @(posedge clk) disable iff (rst_i)
    decouple_i |=> (payload_o == '0)
  ) else $error("rp_decoupler: output not cleared while decoupled");

endmodule

`default_nettype wire

//--- verilog/arith_unit.sv
`timescale 1ns/100ps
`default_nettype none

module arith_unit
  import dpr_alu_pkg::*;
#(
  parameter int DATA_WIDTH = 8
) (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   rm_reset_i,
  input  wire  [DATA_WIDTH-1:0] a_i,
  input  wire  [DATA_WIDTH-1:0] b_i,
  input  alu_op_e               op_sel_i,
  input  wire                   mux_sel_i,
  output logic [DATA_WIDTH-1:0] result_o,
  output cmp_flags_t            flags_o
);

  localparam logic [DATA_WIDTH-1:0] ONE = DATA_WIDTH'(1);

  // Operator bank outputs
  logic [DATA_WIDTH-1:0] add_sum;
  logic [DATA_WIDTH-1:0] dec_d;
  logic [DATA_WIDTH-1:0] div_quot;
  logic [DATA_WIDTH-1:0] inc_d;
  logic [DATA_WIDTH-1:0] mod_rem;
  logic [DATA_WIDTH-1:0] mul_prod;
  logic [DATA_WIDTH-1:0] mux_d;
  logic [DATA_WIDTH-1:0] reg_q;
  logic [DATA_WIDTH-1:0] shl_d;
  logic [DATA_WIDTH-1:0] shr_d;
  logic [DATA_WIDTH-1:0] sub_diff;
  logic                  b_is_zero;

  assign b_is_zero = (b_i == '0);

  // Add, sub, inc, dec all wrap at DATA_WIDTH
  assign add_sum  = a_i + b_i;
  assign sub_diff = a_i - b_i;
  assign inc_d    = a_i + ONE;
  assign dec_d    = a_i - ONE;

  // Product keeps only the low half
  assign mul_prod = a_i * b_i;

  // Divide by zero saturates to all ones
  assign div_quot = b_is_zero ? '1 : a_i / b_i;

  // Modulo by zero passes a through
  assign mod_rem  = b_is_zero ? a_i : a_i % b_i;

  // Logical shifts, amount taken from b
  // Amounts of DATA_WIDTH or more clear the result
  assign shl_d = a_i << b_i;
  assign shr_d = a_i >> b_i;

  // 2:1 mux, b when select high
  assign mux_d = mux_sel_i ? b_i : a_i;

  // Register operator
  // Holds the mux value from the previous edge
  // Cleared by system reset and by the module reset from the controller
  always_ff @(posedge clk) begin
    if (rst_i || rm_reset_i) begin
      reg_q <= '0;
    end else begin
      reg_q <= mux_d;
    end
  end

  // Unsigned magnitude comparator
  always_comb begin
    flags_o.lt = (a_i < b_i);
    flags_o.gt = (a_i > b_i);
    flags_o.eq = (a_i == b_i);
  end

  // Operation select
  always_comb begin
    case (op_sel_i)
      OP_ADD:  result_o = add_sum;
      OP_DEC:  result_o = dec_d;
      OP_DIV:  result_o = div_quot;
      OP_INC:  result_o = inc_d;
      OP_MOD:  result_o = mod_rem;
      OP_MUL:  result_o = mul_prod;
      OP_MUX:  result_o = mux_d;
      OP_REG:  result_o = reg_q;
      OP_SHL:  result_o = shl_d;
      OP_SHR:  result_o = shr_d;
      OP_SUB:  result_o = sub_diff;
      // Unused codes
      default: result_o = '0;
    endcase
  end

  // Comparator must always resolve to a single relation
  a_cmp_onehot: assert property (
    @(posedge clk) disable iff (rst_i)
    $onehot({flags_o.lt, flags_o.gt, flags_o.eq})
  ) else $error("arith_unit: comparator flags not one-hot");

endmodule

`default_nettype wire

//--- verilog/dpr_ctrl_pkg.sv
`default_nettype none

package dpr_ctrl_pkg;

  // States of the reconfiguration controller
  // RM_ACTIVE      module coupled and running
  // RM_DECOUPLED   outputs isolated, waiting for startup
  // RM_RESETTING   still isolated, module reset applied
  typedef enum logic [1:0] {
    RM_ACTIVE    = 2'd0,
    RM_DECOUPLED = 2'd1,
    RM_RESETTING = 2'd2
  } rm_state_e;

  // Length of the module reset pulse in clock cycles
  localparam int DEFAULT_RM_RESET_CYCLES = 2;

endpackage

`default_nettype wire

//--- verilog/dpr_alu_pkg.sv
`default_nettype none

package dpr_alu_pkg;

  // Width of the operation code word
  localparam int OP_SEL_WIDTH = 5;

  // Operand width used when the top level is left at its default
  localparam int DEFAULT_DATA_WIDTH = 8;

  // Operation codes of the arithmetic unit
  // Codes above OP_SUB select a zero result
  typedef enum logic [OP_SEL_WIDTH-1:0] {
    OP_ADD = 0,
    OP_DEC = 1,
    OP_DIV = 2,
    OP_INC = 3,
    OP_MOD = 4,
    OP_MUL = 5,
    OP_MUX = 6,
    OP_REG = 7,
    OP_SHL = 8,
    OP_SHR = 9,
    OP_SUB = 10
  } alu_op_e;

  // Magnitude comparator flags for a against b
  // Unsigned compare with exactly one bit set at a time
  typedef struct packed {
    logic lt;
    logic gt;
    logic eq;
  } cmp_flags_t;

endpackage

`default_nettype wire
